/* apb_pkg.sv */
package apb_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  prot_t;
    typedef logic [31:0] delay_count_t;  // Fixed point, delay_frac_bits of fraction

    // Stretcher timing
    localparam int delay_frac_bits = 10;
    localparam int delay_ratio = 9;
    localparam delay_count_t delay_step = delay_count_t'(delay_ratio) << delay_frac_bits;

    // Memory slave
    localparam int sram_wait_states = 2;
    localparam int sram_wait_bits = $clog2(sram_wait_states + 1);
    localparam addr_t sram_base = 32'h0000_0000;
    localparam int sram_words = 256;
    localparam int sram_index_bits = $clog2(sram_words);
    localparam addr_t sram_bytes = addr_t'(sram_words * 4);

    // Register slave
    localparam addr_t regs_base = 32'h0001_0000;
    localparam addr_t regs_bytes = 32'h0000_1000;
    localparam int regs_scratch_count = 4;
    localparam int regs_scratch_bits = $clog2(regs_scratch_count);
    localparam addr_t regs_id_offset = 32'h0000_0010;
    localparam data_t regs_id_value = 32'h4150_4231;

    typedef logic [sram_index_bits-1:0]   sram_index_t;
    typedef logic [sram_wait_bits-1:0]    sram_wait_t;
    typedef logic [regs_scratch_bits-1:0] scratch_index_t;

    typedef struct packed {
        addr_t paddr;
        prot_t pprot;   // Carried but not checked
        logic  pwrite;
        data_t pwdata;
        strb_t pstrb;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        data_t prdata;
        logic  pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        delayer_idle,
        delayer_active,
        delayer_delay
    } delayer_state_t;

    typedef enum logic [1:0] {
        sram_idle,
        sram_wait,
        sram_done
    } sram_state_t;

endpackage

/* apb_delayer.sv */
`timescale 1ns/1ps

module apb_delayer (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t in_req,
    input  logic              in_psel,
    input  logic              in_penable,
    output apb_pkg::apb_rsp_t in_rsp,
    output apb_pkg::apb_req_t out_req,
    output logic              out_psel,
    output logic              out_penable,
    input  apb_pkg::apb_rsp_t out_rsp
);

    apb_pkg::delayer_state_t state;
    apb_pkg::delay_count_t   delay_count;
    apb_pkg::data_t          held_prdata;
    logic                    held_pslverr;
    logic                    pass_through;

    assign out_req = in_req;

    // Downstream sees nothing once the response is captured or being returned
    assign pass_through = (state != apb_pkg::delayer_delay) && !in_rsp.pready;
    assign out_psel = in_psel && pass_through;
    assign out_penable = in_penable && pass_through;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= apb_pkg::delayer_idle;
        end else begin
            case (state)
                apb_pkg::delayer_idle: begin
                    if (in_psel && !in_penable) begin  // Setup cycle
                        state <= apb_pkg::delayer_active;
                    end
                end
                apb_pkg::delayer_active: begin
                    if (out_rsp.pready) begin
                        state <= apb_pkg::delayer_delay;
                    end
                end
                apb_pkg::delayer_delay: begin
                    if (delay_count == '0) begin
                        state <= apb_pkg::delayer_idle;
                    end
                end
                default: state <= apb_pkg::delayer_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            delay_count <= '0;
        end else if (state == apb_pkg::delayer_active) begin
            if (!out_rsp.pready) begin
                delay_count <= delay_count + apb_pkg::delay_step;
            end else begin
                delay_count <= delay_count >> apb_pkg::delay_frac_bits;  // Whole cycles
            end
        end else if (state == apb_pkg::delayer_delay && delay_count != '0) begin
            delay_count <= delay_count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (state == apb_pkg::delayer_active && out_rsp.pready) begin
            held_prdata <= out_rsp.prdata;
            held_pslverr <= out_rsp.pslverr;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            in_rsp <= '0;
        end else if (state == apb_pkg::delayer_delay && delay_count == '0) begin
            in_rsp.pready <= 1'b1;
            in_rsp.prdata <= held_prdata;
            in_rsp.pslverr <= held_pslverr;
        end else begin
            in_rsp <= '0;
        end
    end

    upstream_ready_pulse: assert property (@(posedge clock) disable iff (reset)
        in_rsp.pready |=> !in_rsp.pready)
        else $error("Upstream pready held for more than one cycle");

    counter_no_wrap: assert property (@(posedge clock) disable iff (reset)
        (state == apb_pkg::delayer_active && !out_rsp.pready)
        |-> delay_count <= ~apb_pkg::delay_count_t'(0) - apb_pkg::delay_step)
        else $error("Stretch counter about to wrap");

endmodule

/* apb_decoder.sv */
`timescale 1ns/1ps

module apb_decoder (
    input  logic              psel,
    input  apb_pkg::apb_req_t req,
    output logic              sram_sel,
    output logic              regs_sel,
    input  apb_pkg::apb_rsp_t sram_rsp,
    input  apb_pkg::apb_rsp_t regs_rsp,
    output apb_pkg::apb_rsp_t rsp
);

    apb_pkg::addr_t sram_offset;
    apb_pkg::addr_t regs_offset;
    logic           hit_sram;
    logic           hit_regs;

    // Offsets wrap below the base, so one compare covers both ends
    assign sram_offset = req.paddr - apb_pkg::sram_base;
    assign regs_offset = req.paddr - apb_pkg::regs_base;

    assign hit_sram = sram_offset < apb_pkg::sram_bytes;
    assign hit_regs = regs_offset < apb_pkg::regs_bytes;

    assign sram_sel = psel && hit_sram;
    assign regs_sel = psel && hit_regs;

    always_comb begin
        rsp = '0;
        if (sram_sel) begin
            rsp = sram_rsp;
        end else if (regs_sel) begin
            rsp = regs_rsp;
        end else if (psel) begin
            // Unmapped address
            rsp.pready = 1'b1;
            rsp.pslverr = 1'b1;
        end
    end

    always_comb begin
        select_exclusive: assert final (!(sram_sel && regs_sel))
            else $error("Both slave selects high");
    end

endmodule

/* apb_sram.sv */
`timescale 1ns/1ps

module apb_sram (
    input  logic              clock,
    input  logic              reset,
    input  logic              sel,
    input  logic              penable,
    input  apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t rsp
);

    apb_pkg::data_t       mem [apb_pkg::sram_words];
    apb_pkg::sram_state_t state;
    apb_pkg::sram_wait_t  wait_count;
    apb_pkg::addr_t       offset;
    apb_pkg::sram_index_t word_index;
    apb_pkg::data_t       read_data;
    logic                 access;

    assign offset = req.paddr - apb_pkg::sram_base;
    assign word_index = offset[2 +: apb_pkg::sram_index_bits];
    assign access = sel && penable;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= apb_pkg::sram_idle;
            wait_count <= '0;
        end else if (!access) begin
            state <= apb_pkg::sram_idle;  // Abandoned or finished
            wait_count <= '0;
        end else begin
            case (state)
                apb_pkg::sram_idle: begin
                    wait_count <= apb_pkg::sram_wait_t'(1);  // First access cycle counts
                    state <= (apb_pkg::sram_wait_states > 1) ? apb_pkg::sram_wait
                                                             : apb_pkg::sram_done;
                end
                apb_pkg::sram_wait: begin
                    wait_count <= wait_count + 1'b1;
                    if (wait_count == apb_pkg::sram_wait_t'(apb_pkg::sram_wait_states - 1)) begin
                        state <= apb_pkg::sram_done;
                    end
                end
                apb_pkg::sram_done: begin
                    state <= apb_pkg::sram_idle;
                    wait_count <= '0;
                end
                default: state <= apb_pkg::sram_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        read_data <= mem[word_index];  // Address is stable since setup
        if (access && state == apb_pkg::sram_done && req.pwrite) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req.pstrb[lane]) begin
                    mem[word_index][8*lane +: 8] <= req.pwdata[8*lane +: 8];
                end
            end
        end
    end

    assign rsp.pready = access && (state == apb_pkg::sram_done);
    assign rsp.prdata = read_data;
    assign rsp.pslverr = 1'b0;

    ready_after_waits: assert property (@(posedge clock) disable iff (reset)
        rsp.pready |-> sel && penable && $past(sel && penable, apb_pkg::sram_wait_states))
        else $error("Memory ready without a held access");

endmodule

/* apb_regs.sv */
`timescale 1ns/1ps

module apb_regs (
    input  logic              clock,
    input  logic              reset,
    input  logic              sel,
    input  logic              penable,
    input  apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t rsp
);

    apb_pkg::data_t         scratch [apb_pkg::regs_scratch_count];
    apb_pkg::addr_t         offset;
    apb_pkg::addr_t         word_offset;
    apb_pkg::scratch_index_t scratch_index;
    logic                   access;
    logic                   is_scratch;
    logic                   is_id;

    assign offset = req.paddr - apb_pkg::regs_base;
    assign word_offset = offset >> 2;
    assign scratch_index = word_offset[apb_pkg::regs_scratch_bits-1:0];
    assign access = sel && penable;

    assign is_scratch = word_offset < apb_pkg::addr_t'(apb_pkg::regs_scratch_count);
    assign is_id = word_offset == (apb_pkg::regs_id_offset >> 2);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < apb_pkg::regs_scratch_count; i++) begin
                scratch[i] <= '0;
            end
        end else if (access && req.pwrite && is_scratch) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req.pstrb[lane]) begin
                    scratch[scratch_index][8*lane +: 8] <= req.pwdata[8*lane +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp = '0;
        rsp.pready = access;  // No wait states
        if (is_scratch) begin
            rsp.prdata = scratch[scratch_index];
        end else if (is_id) begin
            rsp.prdata = apb_pkg::regs_id_value;
            rsp.pslverr = access && req.pwrite;  // Identifier is read only
        end else begin
            rsp.pslverr = access;
        end
    end

endmodule

/* apb_subsystem.sv */
`timescale 1ns/1ps

module apb_subsystem (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t req,
    input  logic              psel,
    input  logic              penable,
    output apb_pkg::apb_rsp_t rsp
);

    apb_pkg::apb_req_t dn_req;
    logic              dn_psel;
    logic              dn_penable;
    apb_pkg::apb_rsp_t dn_rsp;
    logic              sram_sel;
    logic              regs_sel;
    apb_pkg::apb_rsp_t sram_rsp;
    apb_pkg::apb_rsp_t regs_rsp;

    apb_delayer u_delayer (
        .clock       (clock),
        .reset       (reset),
        .in_req      (req),
        .in_psel     (psel),
        .in_penable  (penable),
        .in_rsp      (rsp),
        .out_req     (dn_req),
        .out_psel    (dn_psel),
        .out_penable (dn_penable),
        .out_rsp     (dn_rsp)
    );

    apb_decoder u_decoder (
        .psel     (dn_psel),
        .req      (dn_req),
        .sram_sel (sram_sel),
        .regs_sel (regs_sel),
        .sram_rsp (sram_rsp),
        .regs_rsp (regs_rsp),
        .rsp      (dn_rsp)
    );

    apb_sram u_sram (
        .clock   (clock),
        .reset   (reset),
        .sel     (sram_sel),
        .penable (dn_penable),
        .req     (dn_req),
        .rsp     (sram_rsp)
    );

    apb_regs u_regs (
        .clock   (clock),
        .reset   (reset),
        .sel     (regs_sel),
        .penable (dn_penable),
        .req     (dn_req),
        .rsp     (regs_rsp)
    );

endmodule

/* tb_apb_tasks.svh */
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

apb_pkg::data_t model_mem [apb_pkg::sram_words];
apb_pkg::data_t model_known [apb_pkg::sram_words];  // Byte lanes written so far
apb_pkg::data_t model_scratch [apb_pkg::regs_scratch_count];

task automatic clear_model();
    for (int i = 0; i < apb_pkg::sram_words; i++) begin
        model_mem[i] = '0;
        model_known[i] = '0;
    end
    for (int i = 0; i < apb_pkg::regs_scratch_count; i++) begin
        model_scratch[i] = '0;
    end
endtask

function automatic apb_pkg::data_t lane_mask(input apb_pkg::strb_t strb);
    apb_pkg::data_t mask;

    mask = '0;
    for (int lane = 0; lane < 4; lane++) begin
        if (strb[lane]) begin
            mask[8*lane +: 8] = 8'hff;
        end
    end
    return mask;
endfunction

// Expected response from the address map; writes land in the model
task automatic predict_response(
    input  apb_pkg::apb_req_t r,
    output apb_pkg::data_t    exp_data,
    output apb_pkg::data_t    exp_mask,  // Lanes of prdata worth checking
    output logic              exp_err,
    output int                exp_latency
);
    apb_pkg::addr_t sram_off;
    apb_pkg::addr_t regs_off;
    apb_pkg::data_t wmask;
    int             index;
    int             waits;

    sram_off = r.paddr - apb_pkg::sram_base;
    regs_off = r.paddr - apb_pkg::regs_base;
    wmask = lane_mask(r.pstrb);
    exp_data = '0;
    exp_mask = r.pwrite ? '0 : '1;  // Write data comes back meaningless
    exp_err = 1'b1;
    waits = 0;
    if (sram_off < apb_pkg::sram_bytes) begin
        index = int'(sram_off >> 2);
        exp_err = 1'b0;
        waits = apb_pkg::sram_wait_states;
        if (r.pwrite) begin
            model_mem[index] = (model_mem[index] & ~wmask) | (r.pwdata & wmask);
            model_known[index] = model_known[index] | wmask;
        end else begin
            exp_data = model_mem[index];
            exp_mask = model_known[index];
        end
    end else if (regs_off < apb_pkg::regs_bytes) begin
        index = int'(regs_off >> 2);
        if (index < apb_pkg::regs_scratch_count) begin
            exp_err = 1'b0;
            if (r.pwrite) begin
                model_scratch[index] = (model_scratch[index] & ~wmask) | (r.pwdata & wmask);
            end else begin
                exp_data = model_scratch[index];
            end
        end else if (index == int'(apb_pkg::regs_id_offset >> 2)) begin
            exp_err = r.pwrite;
            exp_data = apb_pkg::regs_id_value;
        end
    end
    // Each downstream wait cycle is stretched by the delay ratio on top of itself
    exp_latency = (apb_pkg::delay_ratio + 1) * waits + 2;
endtask

// Setup then access phase, latency counted from the first access cycle
task automatic drive_transfer(
    input  apb_pkg::apb_req_t r,
    output apb_pkg::data_t    rdata,
    output logic              err,
    output int                latency,
    output logic              got_ready
);
    int cycles;

    req = r;
    psel = 1'b1;
    penable = 1'b0;
    @(posedge clock);
    #1;
    penable = 1'b1;
    cycles = 0;
    got_ready = 1'b0;
    rdata = '0;
    err = 1'b0;
    while (!got_ready && cycles < 40) begin
        @(negedge clock);  // Middle of the cycle
        if (rsp.pready) begin
            got_ready = 1'b1;
            rdata = rsp.prdata;
            err = rsp.pslverr;
        end else begin
            cycles++;
        end
    end
    latency = cycles;
    @(posedge clock);
    #1;
    psel = 1'b0;
    penable = 1'b0;
endtask

`endif

/* tb_apb_subsystem.sv */
`timescale 1ns/1ps

module tb_apb_subsystem;

    logic              clock;
    logic              reset;
    apb_pkg::apb_req_t req;
    logic              psel;
    logic              penable;
    apb_pkg::apb_rsp_t rsp;

    integer seed = 87;
    int     checks = 0;
    int     errors = 0;
    int     directed_count = 12;
    int     random_count = 300;

    `include "tb_apb_tasks.svh"

    apb_subsystem uut (
        .clock   (clock),
        .reset   (reset),
        .req     (req),
        .psel    (psel),
        .penable (penable),
        .rsp     (rsp)
    );

    always #2 clock = ~clock;  // 4 ns period

    task automatic compare_value(
        input logic [31:0] actual,
        input logic [31:0] expected,
        input string       what
    );
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    function automatic apb_pkg::apb_req_t make_req(
        input apb_pkg::addr_t addr,
        input logic           write,
        input apb_pkg::data_t data,
        input apb_pkg::strb_t strb
    );
        apb_pkg::apb_req_t r;

        r.paddr = addr;
        r.pprot = '0;
        r.pwrite = write;
        r.pwdata = data;
        r.pstrb = strb;
        return r;
    endfunction

    task automatic run_transfer(input apb_pkg::apb_req_t r, input string label);
        apb_pkg::data_t exp_data;
        apb_pkg::data_t exp_mask;
        apb_pkg::data_t got_data;
        logic           exp_err;
        logic           got_err;
        logic           got_ready;
        int             exp_latency;
        int             got_latency;

        predict_response(r, exp_data, exp_mask, exp_err, exp_latency);
        drive_transfer(r, got_data, got_err, got_latency, got_ready);
        if (!got_ready) begin
            errors++;
            $display("No pready for %s transfer to 0x%08h within 40 cycles", label, r.paddr);
        end else begin
            if (exp_mask != '0) begin
                compare_value(got_data & exp_mask, exp_data & exp_mask, {label, " prdata"});
            end
            compare_value(got_err, exp_err, {label, " pslverr"});
            compare_value(got_latency, exp_latency, {label, " latency"});
        end
        @(negedge clock);
        compare_value(rsp.pready, 1'b0, {label, " pready after pulse"});  // One cycle only
        @(posedge clock);
        #1;
    endtask

    task automatic pick_random_request(output apb_pkg::apb_req_t r);
        logic [31:0] bits;
        int          pick;
        int          word;
        int          first_illegal;

        pick = $unsigned($random(seed)) % 20;
        bits = $random(seed);
        r.pwdata = $random(seed);
        r.pstrb = bits[3:0];
        r.pprot = bits[6:4];
        r.pwrite = bits[7];
        first_illegal = int'(apb_pkg::regs_id_offset >> 2) + 1;
        if (pick < 8) begin
            // Mostly a few low words so reads find earlier writes
            word = bits[8] ? int'(bits[23:16]) : int'(bits[18:16]);
            r.paddr = apb_pkg::sram_base + apb_pkg::addr_t'(word * 4);
        end else if (pick < 13) begin
            r.paddr = apb_pkg::regs_base + apb_pkg::addr_t'({bits[17:16], 2'b00});
        end else if (pick < 15) begin
            r.paddr = apb_pkg::regs_base + apb_pkg::regs_id_offset;
        end else if (pick < 18) begin
            word = first_illegal + $unsigned($random(seed))
                   % (int'(apb_pkg::regs_bytes >> 2) - first_illegal);
            r.paddr = apb_pkg::regs_base + apb_pkg::addr_t'(word * 4);
        end else if (bits[9]) begin
            r.paddr = {4'h8, bits[27:10], 10'h000};  // Far above both windows
        end else begin
            r.paddr = apb_pkg::sram_base + apb_pkg::sram_bytes
                      + apb_pkg::addr_t'({bits[21:10], 2'b00});  // Gap below the registers
        end
    endtask

    initial begin
        apb_pkg::apb_req_t r;
        apb_pkg::addr_t    id_addr;

        clock = 1'b0;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        req = '0;
        clear_model();
        id_addr = apb_pkg::regs_base + apb_pkg::regs_id_offset;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        repeat (3) begin
            @(negedge clock);
            compare_value(rsp.pready, 1'b0, "pready after reset");
            compare_value(rsp.prdata, '0, "prdata after reset");
            compare_value(rsp.pslverr, 1'b0, "pslverr after reset");
        end
        @(posedge clock);
        #1;

        for (int i = 0; i < apb_pkg::regs_scratch_count; i++) begin
            r = make_req(apb_pkg::regs_base + apb_pkg::addr_t'(i * 4), 1'b0, '0, '0);
            run_transfer(r, "scratch after reset");
        end
        run_transfer(make_req(id_addr, 1'b0, '0, '0), "identifier read");
        run_transfer(make_req(id_addr, 1'b1, 32'hdead_beef, 4'hf), "identifier write");
        run_transfer(make_req(id_addr, 1'b0, '0, '0), "identifier reread");
        r = make_req(apb_pkg::sram_base + 32'h1c, 1'b1, 32'h1122_3344, 4'hf);
        run_transfer(r, "memory full write");
        r = make_req(apb_pkg::sram_base + 32'h1c, 1'b1, 32'haabb_ccdd, 4'b0101);
        run_transfer(r, "memory merge write");
        run_transfer(make_req(apb_pkg::sram_base + 32'h1c, 1'b0, '0, '0), "memory merge read");
        run_transfer(make_req(32'h9000_0000, 1'b0, '0, '0), "unmapped read");
        r = make_req(apb_pkg::regs_base + 32'h0000_0040, 1'b0, '0, '0);
        run_transfer(r, "illegal offset read");

        for (int n = 0; n < random_count; n++) begin
            pick_random_request(r);
            run_transfer(r, "random");
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized for the worst case transfer plus reset and margin
    initial begin
        int limit_ns;

        limit_ns = (directed_count + random_count) * 30 * 4 + 8 * 4 + 400;
        #(limit_ns);
        $display("Run timed out after %0d ns with transfers still pending", limit_ns);
        $display("Test failed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
apb_pkg.sv
apb_delayer.sv
apb_decoder.sv
apb_sram.sv
apb_regs.sv
apb_subsystem.sv
tb_apb_subsystem.sv
